// File: logic/ooo_cfg_pkg.sv
package ooo_cfg_pkg;

    // station depth, also the number of dispatch credits
    localparam int RS_ENTRIES = 4;
    localparam int RS_IDX_W = $clog2(RS_ENTRIES);

    // same depth as the credit pool, so the rob cannot overflow
    localparam int ROB_ENTRIES = 4;
    localparam int ROB_IDX_W = $clog2(ROB_ENTRIES);

    // tag 0 means ready
    // tags 1..ROB_ENTRIES map onto rob slots 0..ROB_ENTRIES-1
    localparam int TAG_W = $clog2(ROB_ENTRIES + 1);

    // rv32i datapath
    localparam int XLEN = 32;
    localparam int NUM_REGS = 32;
    localparam int REG_IDX_W = $clog2(NUM_REGS);

    // i-type immediate width
    localparam int IMM_W = 12;

endpackage

// File: logic/ooo_types_pkg.sv
package ooo_types_pkg;

    import ooo_cfg_pkg::*;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    // second source field, read as imm or as rs2 depending on use_imm
    typedef union packed {
        logic [IMM_W-1:0] imm;
        struct packed {
            logic [IMM_W-REG_IDX_W-1:0] pad;
            reg_idx_t                   idx;
        } rs2;
    } src2_u;

    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        logic     use_imm;
        src2_u    src2;
    } dispatch_t;

    // tag 0 -> value is valid
    typedef struct packed {
        tag_t  tag;
        word_t value;
    } operand_t;

    typedef struct packed {
        logic     busy;
        alu_op_e  op;
        operand_t src1;
        operand_t src2;
        tag_t     dest;
    } rs_entry_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t value;
    } cdb_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    value;
    } commit_t;

endpackage

// File: logic/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   start_i,
    input  ooo_types_pkg::alu_op_e op_i,
    input  ooo_types_pkg::word_t   a_i,
    input  ooo_types_pkg::word_t   b_i,
    input  logic                   grant_i,
    output logic                   done_o,
    output ooo_types_pkg::word_t   result_o
);

    import ooo_types_pkg::*;

    word_t res;

    // rv32i alu, shift amount from b[4:0]
    always_comb begin
        case (op_i)
            ALU_ADD:  res = a_i + b_i;
            ALU_SUB:  res = a_i - b_i;
            ALU_AND:  res = a_i & b_i;
            ALU_OR:   res = a_i | b_i;
            ALU_XOR:  res = a_i ^ b_i;
            ALU_SLL:  res = a_i << b_i[4:0];
            ALU_SRL:  res = a_i >> b_i[4:0];
            ALU_SRA:  res = word_t'($signed(a_i) >>> b_i[4:0]);
            ALU_SLT:  res = word_t'($signed(a_i) < $signed(b_i));
            ALU_SLTU: res = word_t'(a_i < b_i);
            default:  res = '0;
        endcase
    end

    // done held until the arbiter takes the result
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_o <= 1'b0;
        end else if (start_i) begin
            done_o <= 1'b1;
        end else if (grant_i) begin
            done_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            result_o <= res;
        end
    end

endmodule

// File: logic/alu_rs.sv
`timescale 1ns/1ps

module alu_rs (
    input  logic                                               clk,
    input  logic                                               arst_n_i,
    input  ooo_types_pkg::dispatch_t                           disp_i,
    input  ooo_types_pkg::operand_t                            op1_i,
    input  ooo_types_pkg::operand_t                            op2_i,
    input  ooo_types_pkg::tag_t                                alloc_tag_i,
    input  ooo_types_pkg::cdb_t                                cdb_i,
    input  logic [ooo_cfg_pkg::RS_ENTRIES-1:0]                 grant_i,
    output logic [ooo_cfg_pkg::RS_ENTRIES-1:0]                 done_o,
    output ooo_types_pkg::word_t [ooo_cfg_pkg::RS_ENTRIES-1:0] result_o,
    output ooo_types_pkg::tag_t [ooo_cfg_pkg::RS_ENTRIES-1:0]  dest_o
);

    import ooo_cfg_pkg::*;
    import ooo_types_pkg::*;

    rs_entry_t ent_q [RS_ENTRIES];
    // entry handed to its alu, waiting for a cdb grant
    logic [RS_ENTRIES-1:0] issued_q;
    logic [RS_ENTRIES-1:0] start_q;
    logic [RS_ENTRIES-1:0] ready;

    logic                free_found;
    logic [RS_IDX_W-1:0] free_idx;

    // capture a broadcast value if the operand waits on that tag
    function automatic operand_t wake(input operand_t opnd, input cdb_t bus);
        operand_t res;
        res = opnd;
        if (opnd.tag != '0 && bus.valid && bus.tag == opnd.tag) begin
            res.tag = '0;
            res.value = bus.value;
        end
        return res;
    endfunction

    // lowest free slot
    // credits guarantee one exists whenever dispatch is valid
    always_comb begin
        free_found = 1'b0;
        free_idx = '0;
        for (int i = 0; i < RS_ENTRIES; i++) begin
            if (!free_found && !ent_q[i].busy) begin
                free_found = 1'b1;
                free_idx = RS_IDX_W'(i);
            end
        end
    end

    // both operands captured and alu still idle
    always_comb begin
        for (int i = 0; i < RS_ENTRIES; i++) begin
            ready[i] = ent_q[i].busy && !issued_q[i]
                       && ent_q[i].src1.tag == '0 && ent_q[i].src2.tag == '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ent_q <= '{default: '0};
            issued_q <= '0;
            start_q <= '0;
        end else begin
            for (int i = 0; i < RS_ENTRIES; i++) begin
                // cdb wakeup on waiting operands
                if (ent_q[i].busy) begin
                    ent_q[i].src1 <= wake(ent_q[i].src1, cdb_i);
                    ent_q[i].src2 <= wake(ent_q[i].src2, cdb_i);
                end
                // one-cycle start pulse, a cycle after ready
                start_q[i] <= ready[i];
                if (ready[i]) begin
                    issued_q[i] <= 1'b1;
                end
                // result went out on the cdb, slot is free again
                if (grant_i[i]) begin
                    ent_q[i].busy <= 1'b0;
                    issued_q[i] <= 1'b0;
                end
            end
            if (disp_i.valid && free_found) begin
                ent_q[free_idx].busy <= 1'b1;
                ent_q[free_idx].op <= disp_i.op;
                ent_q[free_idx].src1 <= op1_i;
                ent_q[free_idx].src2 <= op2_i;
                ent_q[free_idx].dest <= alloc_tag_i;
            end
        end
    end

    // one alu per entry, operands stay stable while the entry is busy
    for (genvar g = 0; g < RS_ENTRIES; g++) begin : g_alu
        alu_unit alu_unit_i (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .start_i  (start_q[g]),
            .op_i     (ent_q[g].op),
            .a_i      (ent_q[g].src1.value),
            .b_i      (ent_q[g].src2.value),
            .grant_i  (grant_i[g]),
            .done_o   (done_o[g]),
            .result_o (result_o[g])
        );

        assign dest_o[g] = ent_q[g].dest;
    end

endmodule

// File: logic/reg_rename.sv
`timescale 1ns/1ps

module reg_rename (
    input  logic                                               clk,
    input  logic                                               arst_n_i,
    input  ooo_types_pkg::dispatch_t                           disp_i,
    input  ooo_types_pkg::tag_t                                alloc_tag_i,
    input  ooo_types_pkg::word_t [ooo_cfg_pkg::ROB_ENTRIES-1:0] rob_val_i,
    input  logic [ooo_cfg_pkg::ROB_ENTRIES-1:0]                rob_done_i,
    input  ooo_types_pkg::cdb_t                                cdb_i,
    input  ooo_types_pkg::commit_t                             commit_i,
    input  ooo_types_pkg::tag_t                                commit_tag_i,
    output ooo_types_pkg::operand_t                            op1_o,
    output ooo_types_pkg::operand_t                            op2_o
);

    import ooo_cfg_pkg::*;
    import ooo_types_pkg::*;

    // architectural file and per-register producer tag
    word_t regs_q [NUM_REGS];
    tag_t  rat_q [NUM_REGS];

    // order: arch file, finished rob slot, live cdb, else wait on tag
    function automatic operand_t lookup(input reg_idx_t idx);
        operand_t             res;
        tag_t                 t;
        logic [ROB_IDX_W-1:0] slot;
        t = rat_q[idx];
        slot = ROB_IDX_W'(t - 1'b1);
        res.tag = '0;
        res.value = regs_q[idx];
        if (idx != '0 && t != '0) begin
            if (rob_done_i[slot]) begin
                res.value = rob_val_i[slot];
            end else if (cdb_i.valid && cdb_i.tag == t) begin
                res.value = cdb_i.value;
            end else begin
                res.tag = t;
                res.value = '0;
            end
        end
        return res;
    endfunction

    always_comb begin
        op1_o = lookup(disp_i.rs1);
        if (disp_i.use_imm) begin
            // sign-extended i-type immediate, ready at once
            op2_o.tag = '0;
            op2_o.value = {{(XLEN-IMM_W){disp_i.src2.imm[IMM_W-1]}}, disp_i.src2.imm};
        end else begin
            op2_o = lookup(disp_i.src2.rs2.idx);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs_q <= '{default: '0};
            rat_q <= '{default: '0};
        end else begin
            if (commit_i.valid && commit_i.rd != '0) begin
                regs_q[commit_i.rd] <= commit_i.value;
                // release only if no younger op renamed rd since
                if (rat_q[commit_i.rd] == commit_tag_i) begin
                    rat_q[commit_i.rd] <= '0;
                end
            end
            // new rename wins over a same-cycle release
            if (disp_i.valid && disp_i.rd != '0) begin
                rat_q[disp_i.rd] <= alloc_tag_i;
            end
        end
    end

endmodule

// File: logic/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic                                               clk,
    input  logic                                               arst_n_i,
    input  logic [ooo_cfg_pkg::RS_ENTRIES-1:0]                 done_i,
    input  ooo_types_pkg::word_t [ooo_cfg_pkg::RS_ENTRIES-1:0] result_i,
    input  ooo_types_pkg::tag_t [ooo_cfg_pkg::RS_ENTRIES-1:0]  dest_i,
    output logic [ooo_cfg_pkg::RS_ENTRIES-1:0]                 grant_o,
    output ooo_types_pkg::cdb_t                                cdb_o
);

    import ooo_cfg_pkg::*;

    // highest-priority requester this cycle
    logic [RS_IDX_W-1:0] rr_ptr_q;
    logic [RS_IDX_W-1:0] cand;
    logic [RS_IDX_W-1:0] win_idx;
    logic                any_win;

    // scan from the pointer, wrapping around
    always_comb begin
        grant_o = '0;
        win_idx = '0;
        any_win = 1'b0;
        cand = '0;
        for (int k = 0; k < RS_ENTRIES; k++) begin
            cand = RS_IDX_W'((int'(rr_ptr_q) + k) % RS_ENTRIES);
            if (!any_win && done_i[cand]) begin
                any_win = 1'b1;
                win_idx = cand;
            end
        end
        if (any_win) begin
            grant_o[win_idx] = 1'b1;
        end
    end

    // cdb is valid for exactly one cycle per grant
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_ptr_q <= '0;
            cdb_o <= '0;
        end else begin
            cdb_o.valid <= any_win;
            cdb_o.tag <= dest_i[win_idx];
            cdb_o.value <= result_i[win_idx];
            // winner drops to lowest priority
            if (any_win) begin
                rr_ptr_q <= RS_IDX_W'((int'(win_idx) + 1) % RS_ENTRIES);
            end
        end
    end

endmodule

// File: logic/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                                                clk,
    input  logic                                                arst_n_i,
    input  ooo_types_pkg::dispatch_t                            disp_i,
    input  ooo_types_pkg::cdb_t                                 cdb_i,
    output ooo_types_pkg::tag_t                                 alloc_tag_o,
    output ooo_types_pkg::word_t [ooo_cfg_pkg::ROB_ENTRIES-1:0] rob_val_o,
    output logic [ooo_cfg_pkg::ROB_ENTRIES-1:0]                 rob_done_o,
    output ooo_types_pkg::commit_t                              commit_o,
    output ooo_types_pkg::tag_t                                 commit_tag_o,
    output logic                                                credit_o
);

    import ooo_cfg_pkg::*;
    import ooo_types_pkg::*;

    logic [ROB_IDX_W-1:0] head_q;
    logic [ROB_IDX_W-1:0] tail_q;
    logic [ROB_IDX_W:0]   count_q;

    // per-slot storage
    reg_idx_t                     rd_q [ROB_ENTRIES];
    word_t [ROB_ENTRIES-1:0]      val_q;
    logic [ROB_ENTRIES-1:0]       done_q;

    logic [ROB_IDX_W-1:0] cdb_slot;
    tag_t                 head_tag;
    logic                 cdb_hits_head;
    logic                 do_commit;
    word_t                head_val;

    // slot n carries tag n+1
    assign alloc_tag_o = tag_t'(tail_q) + 1'b1;
    assign head_tag = tag_t'(head_q) + 1'b1;
    assign cdb_slot = ROB_IDX_W'(cdb_i.tag - 1'b1);

    assign rob_val_o = val_q;
    assign rob_done_o = done_q;

    // oldest entry may retire in the same cycle its result is broadcast
    assign cdb_hits_head = cdb_i.valid && cdb_i.tag == head_tag;
    assign do_commit = count_q != '0 && (done_q[head_q] || cdb_hits_head);
    assign head_val = done_q[head_q] ? val_q[head_q] : cdb_i.value;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q <= '0;
            tail_q <= '0;
            count_q <= '0;
            done_q <= '0;
            commit_o <= '0;
            commit_tag_o <= '0;
            credit_o <= 1'b0;
        end else begin
            // done stays set after commit
            // rename may still read the slot for one cycle
            if (cdb_i.valid) begin
                done_q[cdb_slot] <= 1'b1;
            end
            if (disp_i.valid) begin
                done_q[tail_q] <= 1'b0;
                tail_q <= tail_q + 1'b1;
            end

            commit_o.valid <= do_commit;
            commit_o.rd <= rd_q[head_q];
            commit_o.value <= head_val;
            commit_tag_o <= head_tag;
            credit_o <= do_commit;
            if (do_commit) begin
                head_q <= head_q + 1'b1;
            end

            case ({disp_i.valid, do_commit})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (disp_i.valid) begin
            rd_q[tail_q] <= disp_i.rd;
        end
        if (cdb_i.valid) begin
            val_q[cdb_slot] <= cdb_i.value;
        end
    end

endmodule

// File: logic/ooo_alu_core.sv
`timescale 1ns/1ps

module ooo_alu_core (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  ooo_types_pkg::dispatch_t dispatch_i,
    output logic                     credit_o,
    output ooo_types_pkg::commit_t   commit_o
);

    import ooo_cfg_pkg::*;
    import ooo_types_pkg::*;

    // rename and rob
    tag_t                    alloc_tag;
    word_t [ROB_ENTRIES-1:0] rob_val;
    logic [ROB_ENTRIES-1:0]  rob_done;
    tag_t                    commit_tag;
    operand_t                op1;
    operand_t                op2;

    // station to arbiter
    cdb_t                   cdb;
    logic [RS_ENTRIES-1:0]  grant;
    logic [RS_ENTRIES-1:0]  alu_done;
    word_t [RS_ENTRIES-1:0] alu_result;
    tag_t [RS_ENTRIES-1:0]  alu_dest;

    reg_rename reg_rename_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .disp_i       (dispatch_i),
        .alloc_tag_i  (alloc_tag),
        .rob_val_i    (rob_val),
        .rob_done_i   (rob_done),
        .cdb_i        (cdb),
        .commit_i     (commit_o),
        .commit_tag_i (commit_tag),
        .op1_o        (op1),
        .op2_o        (op2)
    );

    alu_rs alu_rs_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .disp_i      (dispatch_i),
        .op1_i       (op1),
        .op2_i       (op2),
        .alloc_tag_i (alloc_tag),
        .cdb_i       (cdb),
        .grant_i     (grant),
        .done_o      (alu_done),
        .result_o    (alu_result),
        .dest_o      (alu_dest)
    );

    cdb_arbiter cdb_arbiter_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .done_i   (alu_done),
        .result_i (alu_result),
        .dest_i   (alu_dest),
        .grant_o  (grant),
        .cdb_o    (cdb)
    );

    reorder_buffer reorder_buffer_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .disp_i       (dispatch_i),
        .cdb_i        (cdb),
        .alloc_tag_o  (alloc_tag),
        .rob_val_o    (rob_val),
        .rob_done_o   (rob_done),
        .commit_o     (commit_o),
        .commit_tag_o (commit_tag),
        .credit_o     (credit_o)
    );

endmodule

// File: tests/ooo_alu_core_tb.sv
`timescale 1ns/1ps

module ooo_alu_core_tb;

    import ooo_cfg_pkg::*;
    import ooo_types_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_OPS = 400;
    // generous per-op budget in cycles
    localparam int WATCHDOG_NS = NUM_OPS * 20 * CLK_PERIOD;

    logic      clk;
    logic      arst_n;
    dispatch_t dispatch;
    logic      credit;
    commit_t   commit;

    // in-order reference state
    word_t       model_regs [NUM_REGS];
    dispatch_t   model_q [$];
    logic [31:0] lfsr_q;
    int          credits;
    int          credit_pulses;
    int          dispatched;

    ooo_alu_core dut_i (
        .clk        (clk),
        .arst_n_i   (arst_n),
        .dispatch_i (dispatch),
        .credit_o   (credit),
        .commit_o   (commit)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("run hung: operations still outstanding after %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // galois lfsr, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one lfsr step per bit
    task automatic draw_bits(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            val = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    // reference alu written from the isa rules
    function automatic word_t model_eval(input dispatch_t d);
        word_t    a;
        word_t    b;
        int       sh;
        a = model_regs[d.rs1];
        if (d.use_imm) begin
            b = {{20{d.src2.imm[11]}}, d.src2.imm};
        end else begin
            b = model_regs[d.src2.rs2.idx];
        end
        sh = b[4:0];
        case (d.op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            // logical shift, then refill the vacated top bits with the sign
            ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            ALU_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            ALU_SLTU: return {31'd0, a < b};
            default:  return '0;
        endcase
    endfunction

    task automatic observe_commit();
        dispatch_t d;
        word_t     exp;
        if (commit.valid) begin
            if (model_q.size() == 0) begin
                $display("commit seen while no operation was outstanding");
                $display("Result: FAILED");
                $fatal(1, "unexpected commit");
            end
            d = model_q.pop_front();
            exp = model_eval(d);
            check_equal("commit_o.rd", commit.rd, d.rd);
            check_equal("commit_o.value", commit.value, exp);
            // x0 commits but is never written
            if (d.rd != '0) begin
                model_regs[d.rd] = exp;
            end
        end
    endtask

    // sample outputs, then drive the next dispatch on the same edge
    task automatic step_cycle(input logic allow_dispatch);
        dispatch_t   d;
        logic [31:0] bits;
        @(posedge clk);
        observe_commit();
        if (credit) begin
            credits++;
            credit_pulses++;
        end
        check_equal("credit_count_in_range", credits <= RS_ENTRIES, 1);
        d = '0;
        if (allow_dispatch && credits != 0) begin
            draw_bits(2, bits);
            // three out of four cycles dispatch
            if (bits[1:0] != 2'b00) begin
                d.valid = 1'b1;
                draw_bits(4, bits);
                d.op = alu_op_e'(bits % 10);
                draw_bits(2, bits);
                d.rd = reg_idx_t'(bits);
                draw_bits(2, bits);
                d.rs1 = reg_idx_t'(bits);
                draw_bits(1, bits);
                d.use_imm = bits[0];
                if (d.use_imm) begin
                    draw_bits(12, bits);
                    d.src2.imm = bits[11:0];
                end else begin
                    draw_bits(2, bits);
                    d.src2.rs2.pad = '0;
                    d.src2.rs2.idx = reg_idx_t'(bits);
                end
                model_q.push_back(d);
                credits--;
                dispatched++;
            end
        end
        dispatch <= d;
    endtask

    initial begin : main
        arst_n = 1'b0;
        dispatch = '0;
        lfsr_q = 32'h3f68;
        credits = RS_ENTRIES;
        credit_pulses = 0;
        dispatched = 0;
        model_regs = '{default: '0};
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        // quiet outputs before the first dispatch
        repeat (4) begin
            @(posedge clk);
            check_equal("commit_o.valid", commit.valid, 0);
            check_equal("credit_o", credit, 0);
        end

        while (dispatched < NUM_OPS) begin
            step_cycle(1'b1);
        end
        while (model_q.size() != 0) begin
            step_cycle(1'b0);
        end
        // idle tail with no stray commit or credit
        repeat (4) begin
            step_cycle(1'b0);
        end

        check_equal("credit_count_final", credits, RS_ENTRIES);
        check_equal("credit_pulses", credit_pulses, dispatched);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: files.f
logic/ooo_cfg_pkg.sv
logic/ooo_types_pkg.sv
logic/alu_unit.sv
logic/alu_rs.sv
logic/reg_rename.sv
logic/cdb_arbiter.sv
logic/reorder_buffer.sv
logic/ooo_alu_core.sv
tests/ooo_alu_core_tb.sv

// File: Bender.yml
package:
  name: ooo_alu_core

sources:
  - files:
      - logic/ooo_cfg_pkg.sv
      - logic/ooo_types_pkg.sv
      - logic/alu_unit.sv
      - logic/alu_rs.sv
      - logic/reg_rename.sv
      - logic/cdb_arbiter.sv
      - logic/reorder_buffer.sv
      - logic/ooo_alu_core.sv
  - target: test
    files:
      - tests/ooo_alu_core_tb.sv
